// ==== rtl/calc_pkg.sv ====
// Calculator shared definitions
`default_nettype none

package calc_pkg;

    // Sign-magnitude number format
    localparam int data_w = 16;
    localparam int mag_w = 15;

    typedef logic [data_w-1:0] calc_t;

    // Operator key codes
    typedef enum logic [2:0] {
        op_none = 3'd0,
        op_neg  = 3'd1,
        op_add  = 3'd2,
        op_sub  = 3'd3,
        op_mul  = 3'd4
    } op_t;

    typedef enum logic [3:0] {
        wait_op1,
        mult_op1,
        add_digit_op1,
        wait_op2,
        mult_op2,
        add_digit_op2,
        send_compute,
        wait_compute,
        show_result
    } state_t;

    // Host register word addresses
    localparam logic [1:0] reg_result = 2'd0;
    localparam logic [1:0] reg_status = 2'd1;
    localparam logic [1:0] reg_ctrl = 2'd2;

    // Status word bits
    localparam int busy_bit = 0;
    localparam int valid_bit = 1;
    localparam int ovf_bit = 2;

endpackage

`default_nettype wire

// ==== rtl/signmag_addsub.sv ====
// Sign-magnitude adder and subtractor
`timescale 1ns/100ps
`default_nettype none

module signmag_addsub (
    input  logic          clk,
    input  logic          nRST,
    input  calc_pkg::calc_t a_in,
    input  calc_pkg::calc_t b_in,
    input  logic          sub,
    input  logic          start,
    output calc_pkg::calc_t out,
    output logic          ovf,
    output logic          finish
);
    import calc_pkg::*;

    logic             a_sign;
    logic             b_sign;
    logic [mag_w-1:0] a_mag;
    logic [mag_w-1:0] b_mag;
    logic [mag_w:0]   sum;
    logic [mag_w-1:0] mag_n;
    logic             sign_n;
    logic             ovf_n;

    always_comb begin
        a_sign = a_in[data_w-1];
        // Subtract is add with b negated
        b_sign = b_in[data_w-1] ^ sub;
        a_mag = a_in[mag_w-1:0];
        b_mag = b_in[mag_w-1:0];
        sum = {1'b0, a_mag} + {1'b0, b_mag};
        ovf_n = 1'b0;
        if (a_sign == b_sign) begin
            mag_n = sum[mag_w-1:0];
            ovf_n = sum[mag_w];
            sign_n = a_sign;
        end else if (a_mag >= b_mag) begin
            mag_n = a_mag - b_mag;
            sign_n = a_sign;
        end else begin
            mag_n = b_mag - a_mag;
            sign_n = b_sign;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            // Zero result always positive
            out <= {sign_n & (|mag_n), mag_n};
            ovf <= ovf_n;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/shift_add_mult.sv ====
// Sequential shift-and-add multiplier
`timescale 1ns/100ps
`default_nettype none

module shift_add_mult (
    input  logic          clk,
    input  logic          nRST,
    input  calc_pkg::calc_t a_in,
    input  calc_pkg::calc_t b_in,
    input  logic          start,
    output calc_pkg::calc_t out,
    output logic          ovf,
    output logic          finish
);
    import calc_pkg::*;

    localparam int cnt_w = $clog2(mag_w);

    logic [2*mag_w-1:0] a_sh;
    logic [mag_w-1:0]   b_sh;
    logic [2*mag_w-1:0] acc;
    logic               sign_q;
    logic [cnt_w-1:0]   cnt;
    logic               running;

    // Control path
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            cnt <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                // Last magnitude bit of b
                if (cnt == cnt_w'(mag_w - 1)) begin
                    running <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    // One partial product per cycle, b consumed LSB first
    always_ff @(posedge clk) begin
        if (start) begin
            a_sh <= {{mag_w{1'b0}}, a_in[mag_w-1:0]};
            b_sh <= b_in[mag_w-1:0];
            acc <= '0;
            sign_q <= a_in[data_w-1] ^ b_in[data_w-1];
        end else if (running) begin
            if (b_sh[0]) begin
                acc <= acc + a_sh;
            end
            a_sh <= a_sh << 1;
            b_sh <= b_sh >> 1;
        end
    end

    // Held until the next start
    assign out = {sign_q & (|acc[mag_w-1:0]), acc[mag_w-1:0]};
    assign ovf = |acc[2*mag_w-1:mag_w];

endmodule

`default_nettype wire

// ==== rtl/calc_control.sv ====
// Calculator controller FSM
`timescale 1ns/100ps
`default_nettype none

module calc_control (
    input  logic          clk,
    input  logic          nRST,
    input  logic [3:0]    keypad_input,
    input  logic          read_input,
    input  calc_pkg::op_t   operator_input,
    input  logic          equal_input,
    input  logic          soft_clr,
    input  calc_pkg::calc_t add_out,
    input  logic          add_ovf,
    input  logic          add_finish,
    input  calc_pkg::calc_t mult_out,
    input  logic          mult_ovf,
    input  logic          mult_finish,
    output logic          key_read,
    output calc_pkg::calc_t add_a,
    output calc_pkg::calc_t add_b,
    output logic          add_sub,
    output logic          add_start,
    output calc_pkg::calc_t mult_a,
    output calc_pkg::calc_t mult_b,
    output logic          mult_start,
    output logic          complete,
    output logic          busy,
    output logic          ovf,
    output calc_pkg::calc_t display_output
);
    import calc_pkg::*;

    localparam calc_t ten = calc_t'(10);

    state_t           state;
    state_t           next_state;
    op_t              op_q;
    logic [mag_w-1:0] mag1;
    logic [mag_w-1:0] mag2;
    logic             neg1;
    logic             neg2;
    logic [3:0]       digit_q;
    calc_t            opnd1;
    calc_t            opnd2;
    logic             waiting;
    logic             key_event;
    logic             digit_key;
    logic             neg_key;
    logic             arith_key;
    logic             unit_done;
    calc_t            unit_out;
    logic             unit_ovf;

    // Raw sign flags, negative zero folded to plus
    assign opnd1 = {neg1 & (|mag1), mag1};
    assign opnd2 = {neg2 & (|mag2), mag2};

    assign waiting = (state == wait_op1) || (state == wait_op2);
    // Key held during the key_read cycle is not taken twice
    assign key_event = read_input && waiting && !key_read;
    assign digit_key = !equal_input && (operator_input == op_none);
    assign neg_key = !equal_input && (operator_input == op_neg);
    assign arith_key = !equal_input && (operator_input inside {op_add, op_sub, op_mul});

    assign unit_done = (op_q == op_mul) ? mult_finish : add_finish;
    assign unit_out = (op_q == op_mul) ? mult_out : add_out;
    assign unit_ovf = (op_q == op_mul) ? mult_ovf : add_ovf;

    assign busy = !waiting;
    assign complete = (state == show_result);

    always_comb begin
        next_state = state;
        case (state)
            wait_op1: begin
                if (key_event && arith_key) begin
                    next_state = wait_op2;
                end else if (key_event && digit_key) begin
                    next_state = mult_op1;
                end
            end
            mult_op1: if (mult_finish) next_state = add_digit_op1;
            add_digit_op1: next_state = wait_op1;
            wait_op2: begin
                if (key_event && equal_input) begin
                    next_state = send_compute;
                end else if (key_event && digit_key) begin
                    next_state = mult_op2;
                end
            end
            mult_op2: if (mult_finish) next_state = add_digit_op2;
            add_digit_op2: next_state = wait_op2;
            send_compute: next_state = wait_compute;
            wait_compute: if (unit_done) next_state = show_result;
            show_result: next_state = wait_op1;
            default: next_state = wait_op1;
        endcase
        if (soft_clr) begin
            next_state = wait_op1;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= wait_op1;
            key_read <= 1'b0;
            add_start <= 1'b0;
            mult_start <= 1'b0;
            op_q <= op_none;
            mag1 <= '0;
            mag2 <= '0;
            neg1 <= 1'b0;
            neg2 <= 1'b0;
            ovf <= 1'b0;
            display_output <= '0;
        end else begin
            state <= next_state;
            key_read <= 1'b0;
            add_start <= 1'b0;
            mult_start <= 1'b0;
            if (soft_clr || state == show_result) begin
                op_q <= op_none;
                mag1 <= '0;
                mag2 <= '0;
                neg1 <= 1'b0;
                neg2 <= 1'b0;
            end else begin
                case (state)
                    wait_op1: begin
                        if (key_event) begin
                            key_read <= 1'b1;
                            if (neg_key) neg1 <= ~neg1;
                            if (arith_key) op_q <= operator_input;
                            if (digit_key) mult_start <= 1'b1;
                        end
                    end
                    mult_op1: if (mult_finish) mag1 <= mult_out[mag_w-1:0];
                    add_digit_op1: mag1 <= mag1 + mag_w'(digit_q);
                    wait_op2: begin
                        // Operator keys other than sign toggle are ignored here
                        if (key_event) begin
                            key_read <= 1'b1;
                            if (neg_key) neg2 <= ~neg2;
                            if (digit_key) mult_start <= 1'b1;
                        end
                    end
                    mult_op2: if (mult_finish) mag2 <= mult_out[mag_w-1:0];
                    add_digit_op2: mag2 <= mag2 + mag_w'(digit_q);
                    send_compute: begin
                        if (op_q == op_mul) begin
                            mult_start <= 1'b1;
                        end else begin
                            add_start <= 1'b1;
                        end
                    end
                    wait_compute: begin
                        if (unit_done) begin
                            display_output <= unit_out;
                            ovf <= unit_ovf;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Operand and digit payload
    always_ff @(posedge clk) begin
        if (key_event && digit_key) begin
            digit_q <= keypad_input;
            mult_a <= (state == wait_op1) ? {1'b0, mag1} : {1'b0, mag2};
            mult_b <= ten;
        end else if (state == send_compute) begin
            mult_a <= opnd1;
            mult_b <= opnd2;
            add_a <= opnd1;
            add_b <= opnd2;
            add_sub <= (op_q == op_sub);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/calc_regs.sv ====
// Wishbone host register block
`timescale 1ns/100ps
`default_nettype none

module calc_regs (
    input  logic          clk,
    input  logic          nRST,
    input  logic          wb_cyc,
    input  logic          wb_stb,
    input  logic          wb_we,
    input  logic [1:0]    wb_adr,
    input  logic [31:0]   wb_dat_i,
    input  calc_pkg::calc_t result,
    input  logic          ovf,
    input  logic          complete,
    input  logic          busy,
    output logic [31:0]   wb_dat_o,
    output logic          wb_ack,
    output logic          soft_clr
);
    import calc_pkg::*;

    logic        req;
    logic        rd_status;
    calc_t       result_q;
    logic        ovf_q;
    logic        valid_q;
    logic [31:0] status_word;
    logic [31:0] rd_data;

    // New strobe only, never a second ack for the same one
    assign req = wb_cyc && wb_stb && !wb_ack;
    assign rd_status = req && !wb_we && (wb_adr == reg_status);

    always_comb begin
        status_word = '0;
        status_word[busy_bit] = busy;
        status_word[valid_bit] = valid_q;
        status_word[ovf_bit] = ovf_q;
    end

    always_comb begin
        case (wb_adr)
            reg_result: rd_data = {{(32-data_w){1'b0}}, result_q};
            reg_status: rd_data = status_word;
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            wb_ack <= 1'b0;
            wb_dat_o <= '0;
            soft_clr <= 1'b0;
            result_q <= '0;
            ovf_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            wb_ack <= req;
            soft_clr <= req && wb_we && (wb_adr == reg_ctrl) && wb_dat_i[0];
            if (req && !wb_we) begin
                wb_dat_o <= rd_data;
            end
            if (complete) begin
                result_q <= result;
                ovf_q <= ovf;
            end
            // A new result wins over a clearing read
            if (complete) begin
                valid_q <= 1'b1;
            end else if (rd_status) begin
                valid_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/calc_top.sv ====
// Calculator core top level
`timescale 1ns/100ps
`default_nettype none

module calc_top (
    input  logic          clk,
    input  logic          nRST,
    input  logic [3:0]    keypad_input,
    input  logic          read_input,
    input  calc_pkg::op_t   operator_input,
    input  logic          equal_input,
    output logic          key_read,
    output logic          complete,
    output calc_pkg::calc_t display_output,
    input  logic          wb_cyc,
    input  logic          wb_stb,
    input  logic          wb_we,
    input  logic [1:0]    wb_adr,
    input  logic [31:0]   wb_dat_i,
    output logic [31:0]   wb_dat_o,
    output logic          wb_ack
);
    import calc_pkg::*;

    calc_t add_a;
    calc_t add_b;
    calc_t add_out;
    logic  add_sub;
    logic  add_start;
    logic  add_ovf;
    logic  add_finish;
    calc_t mult_a;
    calc_t mult_b;
    calc_t mult_out;
    logic  mult_start;
    logic  mult_ovf;
    logic  mult_finish;
    logic  busy;
    logic  ovf;
    logic  soft_clr;

    calc_control control0 (
        .clk(clk), .nRST(nRST),
        .keypad_input(keypad_input), .read_input(read_input),
        .operator_input(operator_input), .equal_input(equal_input),
        .soft_clr(soft_clr),
        .add_out(add_out), .add_ovf(add_ovf), .add_finish(add_finish),
        .mult_out(mult_out), .mult_ovf(mult_ovf), .mult_finish(mult_finish),
        .key_read(key_read),
        .add_a(add_a), .add_b(add_b), .add_sub(add_sub), .add_start(add_start),
        .mult_a(mult_a), .mult_b(mult_b), .mult_start(mult_start),
        .complete(complete), .busy(busy), .ovf(ovf),
        .display_output(display_output)
    );

    signmag_addsub addsub0 (
        .clk(clk), .nRST(nRST),
        .a_in(add_a), .b_in(add_b), .sub(add_sub), .start(add_start),
        .out(add_out), .ovf(add_ovf), .finish(add_finish)
    );

    shift_add_mult mult0 (
        .clk(clk), .nRST(nRST),
        .a_in(mult_a), .b_in(mult_b), .start(mult_start),
        .out(mult_out), .ovf(mult_ovf), .finish(mult_finish)
    );

    calc_regs regs0 (
        .clk(clk), .nRST(nRST),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i),
        .result(display_output), .ovf(ovf), .complete(complete), .busy(busy),
        .wb_dat_o(wb_dat_o), .wb_ack(wb_ack), .soft_clr(soft_clr)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
// Testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic nRST
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        nRST = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        nRST = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/calc_props.sv ====
// Controller handshake assertions
`timescale 1ns/100ps
`default_nettype none

module calc_props (
    input logic clk,
    input logic nRST,
    input logic key_read,
    input logic add_start,
    input logic mult_start,
    input logic complete
);

    key_read_pulse: assert property (@(posedge clk) disable iff (!nRST)
        key_read |=> !key_read)
        else $error("key_read high in two consecutive cycles");

    one_unit_start: assert property (@(posedge clk) disable iff (!nRST)
        !(add_start && mult_start))
        else $error("adder and multiplier started together");

    complete_pulse: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
        else $error("complete high in two consecutive cycles");

endmodule

bind calc_control calc_props props0 (
    .clk(clk),
    .nRST(nRST),
    .key_read(key_read),
    .add_start(add_start),
    .mult_start(mult_start),
    .complete(complete)
);

`default_nettype wire

// ==== bench/calc_tb.sv ====
// Calculator core testbench
`timescale 1ns/100ps
`default_nettype none

module calc_tb;
    import calc_pkg::*;

    localparam int key_limit = 100;
    localparam int wb_limit = 20;
    localparam int done_limit = 100;
    localparam int idle_limit = 50;

    logic        clk;
    logic        nRST;
    logic [3:0]  keypad_input;
    logic        read_input;
    op_t         operator_input;
    logic        equal_input;
    logic        key_read;
    logic        complete;
    calc_t       display_output;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack;
    int          seed;

    tb_clock clock0 (
        .clk(clk),
        .nRST(nRST)
    );

    calc_top dut0 (
        .clk(clk), .nRST(nRST),
        .keypad_input(keypad_input), .read_input(read_input),
        .operator_input(operator_input), .equal_input(equal_input),
        .key_read(key_read), .complete(complete), .display_output(display_output),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack)
    );

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Errors found");
        $fatal(1, "Timeout");
    endtask

    // Zero magnitude never negative
    function automatic calc_t make_num(input logic neg, input logic [14:0] mag);
        return {neg & (mag != 15'd0), mag};
    endfunction

    // Signed integer model returning {ovf, result}
    function automatic logic [16:0] addsub_model(input calc_t a, input calc_t b,
                                                 input logic sub);
        int va;
        int vb;
        int r;
        int m;
        va = a[15] ? -int'(a[14:0]) : int'(a[14:0]);
        vb = b[15] ? -int'(b[14:0]) : int'(b[14:0]);
        r = sub ? va - vb : va + vb;
        m = (r < 0) ? -r : r;
        return {m >= 32768, make_num(r < 0, 15'(m))};
    endfunction

    function automatic logic [16:0] mult_model(input calc_t a, input calc_t b);
        int p;
        p = int'(a[14:0]) * int'(b[14:0]);
        return {p >= 32768, make_num(a[15] ^ b[15], 15'(p))};
    endfunction

    task automatic random_below(input int limit, output int value);
        int r;
        r = $random(seed);
        value = int'((r & 32'h7fff_ffff) % limit);
    endtask

    // Key held until key_read and released afterwards
    task automatic send_key(input logic [3:0] digit, input op_t op, input logic eq);
        int waited;
        @(negedge clk);
        keypad_input = digit;
        operator_input = op;
        equal_input = eq;
        read_input = 1'b1;
        waited = 0;
        while (!key_read) begin
            if (waited == key_limit) report_timeout("key_read");
            @(negedge clk);
            waited++;
        end
        read_input = 1'b0;
        operator_input = op_none;
        equal_input = 1'b0;
    endtask

    task automatic press_digit(input logic [3:0] digit);
        send_key(digit, op_none, 1'b0);
    endtask

    task automatic press_op(input op_t op);
        send_key(4'd0, op, 1'b0);
    endtask

    task automatic press_equal();
        send_key(4'd0, op_none, 1'b1);
    endtask

    task automatic wait_complete();
        int waited;
        waited = 0;
        while (!complete) begin
            if (waited == done_limit) report_timeout("complete");
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic wb_cycle(input logic we, input logic [1:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_i = wdata;
        waited = 0;
        while (!wb_ack) begin
            if (waited == wb_limit) report_timeout("wb_ack");
            @(negedge clk);
            waited++;
        end
        rdata = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
        wb_cycle(1'b0, adr, 32'd0, data);
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, data, unused);
    endtask

    // Poll the busy bit until the controller is back in a wait state
    task automatic wait_idle();
        logic [31:0] status;
        int polls;
        polls = 0;
        wb_read(reg_status, status);
        while (status[busy_bit]) begin
            if (polls == idle_limit) report_timeout("controller idle");
            wb_read(reg_status, status);
            polls++;
        end
    endtask

    task automatic enter_number(input int value, input logic negate);
        int digit_buf [6];
        int count;
        int v;
        int i;
        v = value;
        count = 0;
        do begin
            digit_buf[count] = v % 10;
            v = v / 10;
            count++;
        end while (v > 0);
        for (i = count - 1; i >= 0; i--) begin
            press_digit(4'(digit_buf[i]));
        end
        if (negate) press_op(op_neg);
    endtask

    task automatic run_calc(input int a, input logic neg_a, input op_t op,
                            input int b, input logic neg_b);
        enter_number(a, neg_a);
        press_op(op);
        enter_number(b, neg_b);
        press_equal();
        wait_complete();
    endtask

    task automatic digit_entry_add();
        logic [31:0] data;
        run_calc(12, 1'b0, op_add, 345, 1'b0);
        check_eq("add display", 32'd357, 32'(display_output));
        wb_read(reg_result, data);
        check_eq("add reg_result", 32'd357, data);
        wb_read(reg_status, data);
        check_eq("add valid", 32'd1, 32'(data[valid_bit]));
        check_eq("add ovf", 32'd0, 32'(data[ovf_bit]));
    endtask

    task automatic negative_subtract();
        logic [31:0] data;
        run_calc(20, 1'b0, op_sub, 75, 1'b0);
        check_eq("sub negative", 32'(make_num(1'b1, 15'd55)), 32'(display_output));
        wb_read(reg_result, data);
        check_eq("sub reg_result", 32'(make_num(1'b1, 15'd55)), data);
        run_calc(5, 1'b0, op_sub, 5, 1'b0);
        check_eq("sub zero", 32'd0, 32'(display_output));
    endtask

    task automatic sign_toggle_mult();
        logic [31:0] data;
        run_calc(12, 1'b1, op_mul, 11, 1'b0);
        check_eq("mult negative", 32'(make_num(1'b1, 15'd132)), 32'(display_output));
        run_calc(3, 1'b1, op_mul, 4, 1'b1);
        check_eq("mult two negatives", 32'd12, 32'(display_output));
        wb_read(reg_status, data);
        check_eq("mult ovf", 32'd0, 32'(data[ovf_bit]));
    endtask

    task automatic overflow_flags();
        logic [31:0] data;
        run_calc(30000, 1'b0, op_add, 5000, 1'b0);
        check_eq("add overflow display", 32'd2232, 32'(display_output));
        wb_read(reg_status, data);
        check_eq("add overflow ovf", 32'd1, 32'(data[ovf_bit]));
        run_calc(200, 1'b0, op_mul, 200, 1'b0);
        check_eq("mult overflow display", 32'd7232, 32'(display_output));
        wb_read(reg_status, data);
        check_eq("mult overflow ovf", 32'd1, 32'(data[ovf_bit]));
        check_eq("mult overflow valid", 32'd1, 32'(data[valid_bit]));
        // Valid is cleared by the first read
        wb_read(reg_status, data);
        check_eq("valid after read", 32'd0, 32'(data[valid_bit]));
    endtask

    task automatic soft_clear_discard();
        enter_number(45, 1'b0);
        press_op(op_add);
        enter_number(6, 1'b0);
        wait_idle();
        wb_write(reg_ctrl, 32'd1);
        run_calc(0, 1'b0, op_add, 7, 1'b0);
        check_eq("soft clear result", 32'd7, 32'(display_output));
    endtask

    task automatic random_operands();
        logic [14:0] mag [2];
        logic        neg [2];
        op_t         op;
        logic [16:0] expected;
        logic [31:0] data;
        int          ndig;
        int          ntog;
        int          d;
        int          i;
        int          j;
        int          k;
        op = op_add;
        for (i = 0; i < 20; i++) begin
            for (k = 0; k < 2; k++) begin
                mag[k] = '0;
                neg[k] = 1'b0;
                random_below(4, ndig);
                for (j = 0; j <= ndig; j++) begin
                    random_below(10, d);
                    press_digit(4'(d));
                    mag[k] = mag[k] * 15'd10 + 15'(d);
                end
                random_below(3, ntog);
                for (j = 0; j < ntog; j++) begin
                    press_op(op_neg);
                    neg[k] = ~neg[k];
                end
                if (k == 0) begin
                    random_below(3, d);
                    op = op_t'(3'(d + 2));
                    press_op(op);
                end
            end
            if (op == op_mul) begin
                expected = mult_model(make_num(neg[0], mag[0]), make_num(neg[1], mag[1]));
            end else begin
                expected = addsub_model(make_num(neg[0], mag[0]), make_num(neg[1], mag[1]),
                                        op == op_sub);
            end
            press_equal();
            wait_complete();
            check_eq($sformatf("random case %0d result", i), 32'(expected[15:0]),
                     32'(display_output));
            wb_read(reg_status, data);
            check_eq($sformatf("random case %0d ovf", i), 32'(expected[16]),
                     32'(data[ovf_bit]));
        end
    endtask

    initial begin
        int waited;
        seed = 32'h86b7;
        keypad_input = 4'd0;
        read_input = 1'b0;
        operator_input = op_none;
        equal_input = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 2'd0;
        wb_dat_i = 32'd0;
        waited = 0;
        while (nRST !== 1'b1) begin
            if (waited == 20) report_timeout("reset release");
            @(negedge clk);
            waited++;
        end
        digit_entry_add();
        negative_subtract();
        sign_toggle_mult();
        overflow_flags();
        soft_clear_discard();
        random_operands();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/calc_pkg.sv
rtl/signmag_addsub.sv
rtl/shift_add_mult.sv
rtl/calc_control.sv
rtl/calc_regs.sv
rtl/calc_top.sv
bench/tb_clock.sv
bench/calc_props.sv
bench/calc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the calculator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module calc_tb -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcalc_tb 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "No errors"; then
    exit 0
else
    echo "Pass message not found"
    exit 1
fi
